/* Bender.yml */
package:
  name: fmpac_cart

sources:
  - common/fmpac_pkg.sv
  - hdl/fmpac_sram.sv
  - hdl/fmpac_mapper.sv
  - opll/opll_regs.sv
  - opll/opll_tone.sv
  - hdl/fmpac_cart.sv
  - target: test
    files:
      - tests/tb_fmpac_cart.sv

/* common/fmpac_pkg.sv */
package fmpac_pkg;

   // In-page offsets of the mapper register window.
   localparam logic [13:0] reg_fm_addr  = 14'h3FF4;
   localparam logic [13:0] reg_fm_data  = 14'h3FF5;
   localparam logic [13:0] reg_enable   = 14'h3FF6;
   localparam logic [13:0] reg_bank     = 14'h3FF7;
   localparam logic [13:0] reg_magic_lo = 14'h1FFE;
   localparam logic [13:0] reg_magic_hi = 14'h1FFF;

   localparam logic [7:0]  enable_mask  = 8'h11;     // Bit 4 is the lock bit.
   localparam logic [15:0] sram_unlock  = 16'h694D;

   // Upper seven bits of the I/O address, so ports 7C and 7D both match.
   localparam logic [6:0]  fm_io_port   = 7'b0111110;

   localparam int num_channels = 9;

   // Layout of registers 20..28.
   typedef struct packed {
      logic [1:0] spare;
      logic       sustain;
      logic       key;
      logic [2:0] block;
      logic       fnum_hi;
   } opll_ctrl_s;

   // The same data byte is the low F-number for registers 10..18
   // and the control fields for registers 20..28.
   typedef union packed {
      logic [7:0] raw;
      opll_ctrl_s ctrl;
   } opll_ctrl_u;

   // Registers 30..38. The stand-in chip has no instruments.
   typedef struct packed {
      logic [3:0] instrument;
      logic [3:0] volume;
   } opll_vol_s;

endpackage

/* files.f */
common/fmpac_pkg.sv
hdl/fmpac_sram.sv
hdl/fmpac_mapper.sv
opll/opll_regs.sv
opll/opll_tone.sv
hdl/fmpac_cart.sv
tests/tb_fmpac_cart.sv

/* hdl/fmpac_cart.sv */
`timescale 1ns/1ps

module fmpac_cart import fmpac_pkg::*; #(
   parameter int phase_bits = 18,
   parameter int sram_words = 8192
) (
   input  logic               clk,
   input  logic               clk_en,
   input  logic               reset,
   input  logic [15:0]        addr,
   input  logic [7:0]         d_from_cpu,
   input  logic               cs,
   input  logic               wr,
   input  logic               rd,     // Part of the slot bus; reads are decoded from cs and wr.
   input  logic               iorq,
   input  logic               m1,
   output logic [7:0]         d_to_cpu,
   output logic               cart_oe,
   output logic signed [15:0] sound,
   output logic [15:0]        mem_addr,
   output logic               mem_oe
);

   logic [7:0]                          map_data;
   logic                                map_hit;
   logic                                sram_oe;
   logic                                sram_we;
   logic [12:0]                         sram_addr;
   logic [7:0]                          sram_dout;
   logic                                fm_wr;
   logic [num_channels-1:0][8:0]        fnum;
   logic [num_channels-1:0][2:0]        block;
   logic [num_channels-1:0]             key;
   logic [num_channels-1:0][3:0]        volume;

   fmpac_mapper fmpac_mapper_i (
      .clk        (clk),
      .reset      (reset),
      .addr       (addr),
      .d_from_cpu (d_from_cpu),
      .cs         (cs),
      .wr         (wr),
      .iorq       (iorq),
      .m1         (m1),
      .map_data   (map_data),
      .map_hit    (map_hit),
      .sram_oe    (sram_oe),
      .sram_we    (sram_we),
      .sram_addr  (sram_addr),
      .mem_addr   (mem_addr),
      .mem_oe     (mem_oe),
      .fm_wr      (fm_wr)
   );

   opll_regs opll_regs_i (
      .clk    (clk),
      .reset  (reset),
      .fm_wr  (fm_wr),
      .a0     (addr[0]),
      .din    (d_from_cpu),
      .fnum   (fnum),
      .block  (block),
      .key    (key),
      .volume (volume)
   );

   opll_tone #(
      .phase_bits (phase_bits)
   ) opll_tone_i (
      .clk    (clk),
      .reset  (reset),
      .clk_en (clk_en),
      .fnum   (fnum),
      .block  (block),
      .key    (key),
      .volume (volume),
      .sound  (sound)
   );

   fmpac_sram #(
      .sram_words (sram_words)
   ) fmpac_sram_i (
      .clk  (clk),
      .we   (sram_we),
      .addr (sram_addr),
      .din  (d_from_cpu),
      .dout (sram_dout)
   );

   // Register window first, then SRAM. Nothing driving reads as open bus.
   assign d_to_cpu = map_hit ? map_data  :
                     sram_oe ? sram_dout :
                               8'hFF;
   assign cart_oe  = map_hit | sram_oe;

endmodule

/* hdl/fmpac_mapper.sv */
`timescale 1ns/1ps

module fmpac_mapper import fmpac_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] addr,
   input  logic [7:0]  d_from_cpu,
   input  logic        cs,
   input  logic        wr,
   input  logic        iorq,
   input  logic        m1,
   output logic [7:0]  map_data,
   output logic        map_hit,
   output logic        sram_oe,
   output logic        sram_we,
   output logic [12:0] sram_addr,
   output logic [15:0] mem_addr,
   output logic        mem_oe,
   output logic        fm_wr
);

   logic [7:0]  enable;
   logic [1:0]  bank;
   logic [7:0]  magic_lo;
   logic [7:0]  magic_hi;
   logic        fm_pulse;
   logic        unlocked;
   logic        io_wr;
   logic [13:0] offset;

   assign offset   = addr[13:0];
   assign unlocked = ({magic_hi, magic_lo} == sram_unlock);

   // Register read mux. The magic bytes only show up once the SRAM is unlocked,
   // otherwise those offsets fall through to the SRAM/ROM decode.
   always_comb begin
      map_data = 8'hFF;
      map_hit  = 1'b0;
      case (offset)
         reg_enable: begin
            map_data = enable;
            map_hit  = 1'b1;
         end
         reg_bank: begin
            map_data = {6'b000000, bank};
            map_hit  = 1'b1;
         end
         reg_magic_lo: begin
            map_data = magic_lo;
            map_hit  = unlocked;
         end
         reg_magic_hi: begin
            map_data = magic_hi;
            map_hit  = unlocked;
         end
         default: ;
      endcase
      map_hit = map_hit & cs & ~wr;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         enable   <= 8'h00;
         bank     <= 2'b00;
         magic_lo <= 8'h00;
         magic_hi <= 8'h00;
         fm_pulse <= 1'b0;
      end else begin
         fm_pulse <= 1'b0;
         if (cs & wr) begin
            case (offset)
               reg_magic_lo: if (~enable[4]) magic_lo <= d_from_cpu;
               reg_magic_hi: if (~enable[4]) magic_hi <= d_from_cpu;
               reg_fm_addr,
               reg_fm_data: fm_pulse <= 1'b1;     // Goes out one cycle after the bus write.
               reg_enable: begin
                  enable <= d_from_cpu & enable_mask;
                  // Rewriting the enable while locked wipes the unlock code.
                  if (enable[4]) begin
                     magic_lo <= 8'h00;
                     magic_hi <= 8'h00;
                  end
               end
               reg_bank: bank <= d_from_cpu[1:0];
               default: ;
            endcase
         end
      end
   end

   assign io_wr = wr & iorq & ~m1 & (addr[7:1] == fm_io_port);
   assign fm_wr = fm_pulse | io_wr;

   assign sram_oe   = cs & unlocked & ~addr[13];   // Lower 8 KB of the page.
   assign sram_we   = sram_oe & wr;
   assign sram_addr = addr[12:0];

   assign mem_addr  = {bank, offset};
   assign mem_oe    = cs;

endmodule

/* hdl/fmpac_sram.sv */
`timescale 1ns/1ps

module fmpac_sram #(
   parameter int sram_words = 8192
) (
   input  logic        clk,
   input  logic        we,
   input  logic [12:0] addr,
   input  logic [7:0]  din,
   output logic [7:0]  dout
);

   logic [7:0] mem [sram_words];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= din;
      end
   end

   assign dout = mem[addr];   // Asynchronous read, like the real part.

endmodule

/* opll/opll_regs.sv */
`timescale 1ns/1ps

module opll_regs import fmpac_pkg::*; (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             fm_wr,
   input  logic                             a0,
   input  logic [7:0]                       din,
   output logic [num_channels-1:0][8:0]     fnum,
   output logic [num_channels-1:0][2:0]     block,
   output logic [num_channels-1:0]          key,
   output logic [num_channels-1:0][3:0]     volume
);

   logic [7:0] reg_idx;
   logic [3:0] ch;
   logic       ch_valid;
   opll_ctrl_u wdata;
   opll_vol_s  vdata;

   assign wdata    = din;
   assign vdata    = din;
   assign ch       = reg_idx[3:0];
   assign ch_valid = (ch < 4'(num_channels));

   // Address port.
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         reg_idx <= 8'h00;
      end else if (fm_wr & ~a0) begin
         reg_idx <= din;
      end
   end

   // Data port. The upper nibble of the index picks the register group
   // and the lower nibble picks the channel.
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         fnum   <= '0;
         block  <= '0;
         key    <= '0;
         volume <= '0;
      end else if (fm_wr & a0 & ch_valid) begin
         case (reg_idx[7:4])
            4'h1: fnum[ch][7:0] <= wdata.raw;
            4'h2: begin
               fnum[ch][8] <= wdata.ctrl.fnum_hi;
               block[ch]   <= wdata.ctrl.block;
               key[ch]     <= wdata.ctrl.key;   // Sustain has no envelope to act on here.
            end
            4'h3: volume[ch] <= vdata.volume;
            default: ;
         endcase
      end
   end

endmodule

/* opll/opll_tone.sv */
`timescale 1ns/1ps

module opll_tone import fmpac_pkg::*; #(
   parameter int phase_bits = 18
) (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             clk_en,
   input  logic [num_channels-1:0][8:0]     fnum,
   input  logic [num_channels-1:0][2:0]     block,
   input  logic [num_channels-1:0]          key,
   input  logic [num_channels-1:0][3:0]     volume,
   output logic signed [15:0]               sound
);

   logic [num_channels-1:0][phase_bits-1:0] phase;
   logic [num_channels-1:0][phase_bits-1:0] step;
   logic [num_channels-1:0][15:0]           amp;
   logic signed [num_channels-1:0][15:0]    contrib;
   logic signed [15:0]                      mix;

   // Per-channel phase increment and square-wave level.
   always_comb begin
      for (int i = 0; i < num_channels; i++) begin
         step[i] = phase_bits'(fnum[i]) << block[i];
         amp[i]  = 16'(4'd15 - volume[i]) << 6;     // Volume 0 is the loudest.
         if (!key[i]) begin
            contrib[i] = 16'sd0;
         end else if (phase[i][phase_bits-1]) begin
            contrib[i] = -$signed(amp[i]);
         end else begin
            contrib[i] = $signed(amp[i]);
         end
      end
   end

   // Nine channels at most 960 each, so 16 bits never overflow.
   always_comb begin
      mix = 16'sd0;
      for (int i = 0; i < num_channels; i++) begin
         mix = mix + contrib[i];
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         phase <= '0;
         sound <= 16'sd0;
      end else if (clk_en) begin
         for (int i = 0; i < num_channels; i++) begin
            if (key[i]) begin
               phase[i] <= phase[i] + step[i];
            end else begin
               phase[i] <= '0;    // Restart the wave on the next key-on.
            end
         end
         sound <= mix;
      end
   end

endmodule

/* tests/tb_fmpac_cart.sv */
`timescale 1ns/1ps

module tb_fmpac_cart import fmpac_pkg::*; ();

   typedef enum logic [2:0] {op_rd, op_rd_nocs, op_wr, op_iowr, op_sound} op_e;

   typedef struct packed {
      op_e         op;
      logic [15:0] addr;
      logic [7:0]  data;     // For a sound step this is the number of keyed channels.
      logic [7:0]  exp;
      logic        exp_oe;
   } step_s;

   localparam logic [1:0]         page          = 2'b01;   // The cartridge sits at 4000..7FFF.
   localparam int                 settle_cycles = 12;
   localparam int                 watch_cycles  = 64;
   localparam logic signed [15:0] full_amp      = 16'sd960;  // (15 - 0) * 64 at volume 0.

   logic               clk = 1'b0;
   logic               clk_en;
   logic               reset;
   logic [15:0]        addr;
   logic [7:0]         d_from_cpu;
   logic               cs;
   logic               wr;
   logic               rd;
   logic               iorq;
   logic               m1;
   logic [7:0]         d_to_cpu;
   logic               cart_oe;
   logic signed [15:0] sound;
   logic [15:0]        mem_addr;
   logic               mem_oe;

   step_s       steps [128];
   int          n_steps = 0;
   int          n_sound = 0;
   int          limit = 0;
   int          cycles = 0;
   logic [1:0]  en_div = 2'd0;
   logic [31:0] lfsr = 32'hc6da_8392;
   logic [1:0]  exp_bank = 2'd0;
   logic [7:0]  rnd [5];
   logic [15:0] spot [5];

   fmpac_cart #(
      .phase_bits (18),
      .sram_words (8192)
   ) fmpac_cart_i (
      .clk        (clk),
      .clk_en     (clk_en),
      .reset      (reset),
      .addr       (addr),
      .d_from_cpu (d_from_cpu),
      .cs         (cs),
      .wr         (wr),
      .rd         (rd),
      .iorq       (iorq),
      .m1         (m1),
      .d_to_cpu   (d_to_cpu),
      .cart_oe    (cart_oe),
      .sound      (sound),
      .mem_addr   (mem_addr),
      .mem_oe     (mem_oe)
   );

   always #5 clk = ~clk;

   // One enable pulse every fourth clock.
   always @(posedge clk) begin
      en_div <= en_div + 2'd1;
      clk_en <= (en_div == 2'd3);
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles > limit) begin
         $display("Timeout: the test table did not finish within %0d cycles", limit);
         $display("Test FAILED");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   task automatic draw_byte(output logic [7:0] b);
      for (int i = 0; i < 8; i++) begin
         b[i] = lfsr[0];          // The bit shifted out is the one taken.
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // Control byte for registers 20..28 with the highest block and F-number bit 8 set.
   function automatic logic [7:0] key_byte(input logic on);
      opll_ctrl_u c;
      c.raw          = 8'h00;
      c.ctrl.key     = on;
      c.ctrl.block   = 3'd7;
      c.ctrl.fnum_hi = 1'b1;
      return c.raw;
   endfunction

   function automatic logic [7:0] vol_byte(input logic [3:0] vol);
      opll_vol_s v;
      v.instrument = 4'd0;
      v.volume     = vol;
      return v;
   endfunction

   task automatic push_step(input op_e op, input logic [15:0] a, input logic [7:0] d,
                            input logic [7:0] e, input logic oe);
      steps[n_steps].op     = op;
      steps[n_steps].addr   = a;
      steps[n_steps].data   = d;
      steps[n_steps].exp    = e;
      steps[n_steps].exp_oe = oe;
      n_steps++;
   endtask

   task automatic expect_read(input logic [15:0] a, input logic [7:0] e, input logic oe);
      push_step(op_rd, a, 8'h00, e, oe);
   endtask

   task automatic post_write(input logic [15:0] a, input logic [7:0] d);
      push_step(op_wr, a, d, 8'h00, 1'b0);
   endtask

   task automatic fm_io(input logic [7:0] idx, input logic [7:0] d);
      push_step(op_iowr, 16'h007C, idx, 8'h00, 1'b0);
      push_step(op_iowr, 16'h007D, d, 8'h00, 1'b0);
   endtask

   task automatic fm_mem(input logic [7:0] idx, input logic [7:0] d);
      post_write({page, reg_fm_addr}, idx);
      post_write({page, reg_fm_data}, d);
   endtask

   task automatic expect_sound(input int n);
      push_step(op_sound, 16'h0000, 8'(n), 8'h00, 1'b0);
      n_sound++;
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
         $display("Test FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
         $display("Test FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_addr(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
         $display("Test FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // Each keyed channel adds plus or minus the full amplitude.
   task automatic check_sound(input logic signed [15:0] got, input int n);
      logic ok;
      ok = 1'b0;
      for (int k = 0; k <= n; k++) begin
         if (got == (2 * k - n) * full_amp) ok = 1'b1;
      end
      if (!ok) begin
         $display("FAIL t=%0t sound got %0d expected a sum of %0d channels at +/-%0d",
                  $time, got, n, full_amp);
         $display("Test FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic watch_sound(input int n);
      logic seen_pos;
      logic seen_neg;
      seen_pos = 1'b0;
      seen_neg = 1'b0;
      repeat (settle_cycles) @(posedge clk);
      repeat (watch_cycles) begin
         @(negedge clk);
         check_sound(sound, n);
         if (sound > 0) seen_pos = 1'b1;
         if (sound < 0) seen_neg = 1'b1;
      end
      if (n == 1 && !(seen_pos && seen_neg)) begin
         $display("Error at t=%0t: a single keyed channel never swung to both signs", $time);
         $display("Test FAILED");
         $fatal(1, "square wave stuck");
      end
   endtask

   task automatic run_step(input step_s s);
      @(posedge clk);
      case (s.op)
         op_rd, op_rd_nocs: begin
            addr <= s.addr;
            cs   <= (s.op == op_rd);
            rd   <= 1'b1;
         end
         op_wr: begin
            addr       <= s.addr;
            d_from_cpu <= s.data;
            cs         <= 1'b1;
            wr         <= 1'b1;
         end
         op_iowr: begin
            addr       <= s.addr;
            d_from_cpu <= s.data;
            iorq       <= 1'b1;
            wr         <= 1'b1;
         end
         default: ;
      endcase
      @(negedge clk);
      if (s.op == op_rd || s.op == op_rd_nocs) begin
         check_byte("d_to_cpu", d_to_cpu, s.exp);
         check_bit("cart_oe", cart_oe, s.exp_oe);
         check_bit("mem_oe", mem_oe, s.op == op_rd);
         check_addr("mem_addr", mem_addr, {exp_bank, s.addr[13:0]});
      end
      if (s.op == op_wr && s.addr[13:0] == reg_bank) exp_bank = s.data[1:0];
      @(posedge clk);
      cs   <= 1'b0;     // Address and data stay put for the delayed FM pulse.
      wr   <= 1'b0;
      rd   <= 1'b0;
      iorq <= 1'b0;
      if (s.op == op_sound) watch_sound(int'(s.data));
   endtask

   initial begin
      reset      = 1'b1;
      clk_en     = 1'b0;
      addr       = 16'h0000;
      d_from_cpu = 8'h00;
      cs         = 1'b0;
      wr         = 1'b0;
      rd         = 1'b0;
      iorq       = 1'b0;
      m1         = 1'b0;
      spot[0]    = 16'h4000;
      spot[1]    = 16'h4001;
      spot[2]    = 16'h4555;
      spot[3]    = 16'h5234;
      spot[4]    = 16'h5FFD;
      for (int i = 0; i < 5; i++) draw_byte(rnd[i]);

      expect_read({page, reg_enable}, 8'h00, 1'b1);
      expect_read({page, reg_bank}, 8'h00, 1'b1);
      expect_read(16'h4100, 8'hFF, 1'b0);
      push_step(op_rd_nocs, {page, reg_enable}, 8'h00, 8'hFF, 1'b0);

      post_write({page, reg_enable}, 8'hFF);
      expect_read({page, reg_enable}, 8'h11, 1'b1);
      post_write({page, reg_bank}, 8'h03);
      expect_read({page, reg_bank}, 8'h03, 1'b1);
      expect_read(16'h4123, 8'hFF, 1'b0);
      post_write({page, reg_enable}, 8'h00);
      expect_read({page, reg_enable}, 8'h00, 1'b1);

      post_write({page, reg_magic_lo}, sram_unlock[7:0]);
      post_write({page, reg_magic_hi}, sram_unlock[15:8]);
      for (int i = 0; i < 5; i++) post_write(spot[i], rnd[i]);
      for (int i = 0; i < 5; i++) expect_read(spot[i], rnd[i], 1'b1);
      expect_read({page, reg_magic_lo}, 8'h4D, 1'b1);
      expect_read({page, reg_magic_hi}, 8'h69, 1'b1);

      // Lock, try to overwrite the code, then rewrite the enable to wipe it.
      post_write({page, reg_enable}, 8'h10);
      expect_read({page, reg_enable}, 8'h10, 1'b1);
      post_write({page, reg_magic_lo}, 8'h00);
      post_write({page, reg_magic_hi}, 8'h00);
      expect_read({page, reg_magic_lo}, 8'h4D, 1'b1);
      expect_read({page, reg_magic_hi}, 8'h69, 1'b1);
      expect_read(spot[0], rnd[0], 1'b1);
      post_write({page, reg_enable}, 8'h00);
      expect_read({page, reg_magic_lo}, 8'hFF, 1'b0);
      expect_read({page, reg_magic_hi}, 8'hFF, 1'b0);
      expect_read(spot[0], 8'hFF, 1'b0);
      expect_read({page, reg_enable}, 8'h00, 1'b1);

      fm_io(8'h10, 8'hFF);
      fm_io(8'h20, key_byte(1'b1));
      fm_io(8'h30, vol_byte(4'd0));
      expect_sound(1);
      fm_io(8'h20, key_byte(1'b0));
      expect_sound(0);

      fm_io(8'h20, key_byte(1'b1));
      fm_mem(8'h11, 8'hFF);
      fm_mem(8'h21, key_byte(1'b1));
      fm_mem(8'h31, vol_byte(4'd0));
      expect_sound(2);

      limit = n_steps * 4 + n_sound * (settle_cycles + watch_cycles) + 100;

      repeat (8) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < n_steps; i++) run_step(steps[i]);
      $display("Test OK");
      $finish;
   end

endmodule
